// File: mem_pkg.sv
package mem_pkg;

   // CPU word and SRAM half-word widths
   localparam int DATA_BITS = 32;
   localparam int HALF_BITS = 16;

   // CPU word address and external SRAM address widths
   localparam int ADDR_BITS      = 20;
   localparam int SRAM_ADDR_BITS = 18;

   // One CPU bus cycle request, held steady while the CPU is stalled
   typedef struct packed {
      logic                 vpa;
      logic                 vda;
      logic                 vio;
      logic                 rnw;
      logic [ADDR_BITS-1:0] address;
      logic [DATA_BITS-1:0] wdata;
   } cpu_bus_t;

   // Outputs towards the external asynchronous SRAM
   typedef struct packed {
      logic                      cs_b;
      logic                      oe_b;
      logic                      we_b;
      logic [SRAM_ADDR_BITS-1:0] addr;
      logic [HALF_BITS-1:0]      data_out;
      // High while the controller drives the SRAM data bus
      logic                      data_oe;
   } sram_pins_t;

   // SRAM controller FSM, one state per phase of a word access
   typedef enum logic [1:0] {
      IDLE,
      LOW_HALF,
      HIGH_HALF,
      DONE
   } sram_state_t;

endpackage

// File: block_ram.sv
`timescale 1ns/10ps

module block_ram #(
   parameter int RAM_ADDR_BITS = 12
) (
   input  logic                          clk,
   input  logic                          pwr_up_reset_b,
   input  logic                          cs_b,
   input  logic                          rnw,
   input  logic [RAM_ADDR_BITS-1:0]      address,
   input  logic [mem_pkg::DATA_BITS-1:0] wdata,
   output logic [mem_pkg::DATA_BITS-1:0] rdata,
   output logic                          ready
);

   import mem_pkg::*;

   localparam int DEPTH = 2 ** RAM_ADDR_BITS;

   logic [DATA_BITS-1:0] mem [DEPTH];

   // Registered copy of ready; high means the previous cycle completed
   logic ready_q;

   // Every selected access is held off for one cycle after a completed one
   assign ready = !ready_q || cs_b;

   always_ff @(posedge clk)
   begin
      if (!pwr_up_reset_b)
      begin
         ready_q <= 1'b0;
      end
      else
      begin
         ready_q <= ready;
      end
   end

   // Read word is registered on the wait-state edge
   always_ff @(posedge clk)
   begin
      if (!cs_b)
      begin
         rdata <= mem[address];
      end
   end

   // Writes land only on the completing edge
   always_ff @(posedge clk)
   begin
      if (!cs_b && !rnw && ready)
      begin
         mem[address] <= wdata;
      end
   end

endmodule

// File: sram_controller.sv
`timescale 1ns/10ps

module sram_controller (
   input  logic                          clk,
   input  logic                          pwr_up_reset_b,
   input  logic                          cs_b,
   input  logic                          rnw,
   input  logic [mem_pkg::ADDR_BITS-1:0] address,
   input  logic [mem_pkg::DATA_BITS-1:0] wdata,
   input  logic [mem_pkg::HALF_BITS-1:0] sram_data_in,
   output logic [mem_pkg::DATA_BITS-1:0] rdata,
   output logic                          ready,
   output mem_pkg::sram_pins_t           sram
);

   import mem_pkg::*;

   sram_state_t state;
   sram_state_t state_next;

   // True when the next cycle drives one of the two halves
   logic in_half_next;
   logic high_next;

   // Registered SRAM strobes
   logic cs_b_q;
   logic oe_b_q;
   logic we_b_q;
   logic data_oe_q;

   // Registered SRAM address and write half-word
   logic [SRAM_ADDR_BITS-1:0] addr_q;
   logic [HALF_BITS-1:0]      data_out_q;

   always_comb
   begin
      state_next = state;
      case (state)
         IDLE:
         begin
            if (!cs_b)
            begin
               state_next = LOW_HALF;
            end
         end
         LOW_HALF:
         begin
            state_next = HIGH_HALF;
         end
         HIGH_HALF:
         begin
            state_next = DONE;
         end
         DONE:
         begin
            state_next = IDLE;
         end
         default:
         begin
            state_next = IDLE;
         end
      endcase
   end

   assign high_next    = (state_next == HIGH_HALF);
   assign in_half_next = (state_next == LOW_HALF) || high_next;

   // Strobes are set up one edge ahead so they stay glitch free
   always_ff @(posedge clk)
   begin
      if (!pwr_up_reset_b)
      begin
         state     <= IDLE;
         cs_b_q    <= 1'b1;
         oe_b_q    <= 1'b1;
         we_b_q    <= 1'b1;
         data_oe_q <= 1'b0;
      end
      else
      begin
         state     <= state_next;
         cs_b_q    <= !in_half_next;
         oe_b_q    <= !(in_half_next && rnw);
         we_b_q    <= !(in_half_next && !rnw);
         data_oe_q <= in_half_next && !rnw;
      end
   end

   // Even SRAM address holds the low half, odd the high half
   always_ff @(posedge clk)
   begin
      addr_q     <= {address[SRAM_ADDR_BITS-2:0], high_next};
      data_out_q <= high_next ? wdata[DATA_BITS-1:HALF_BITS] : wdata[HALF_BITS-1:0];
   end

   // Capture each read half at the end of its state; word held through DONE
   always_ff @(posedge clk)
   begin
      if (state == LOW_HALF)
      begin
         rdata[HALF_BITS-1:0] <= sram_data_in;
      end
      if (state == HIGH_HALF)
      begin
         rdata[DATA_BITS-1:HALF_BITS] <= sram_data_in;
      end
   end

   assign ready = (state == DONE);

   assign sram.cs_b     = cs_b_q;
   assign sram.oe_b     = oe_b_q;
   assign sram.we_b     = we_b_q;
   assign sram.addr     = addr_q;
   assign sram.data_out = data_out_q;
   assign sram.data_oe  = data_oe_q;

endmodule

// File: bus_decoder.sv
`timescale 1ns/10ps

module bus_decoder #(
   parameter int RAM_ADDR_BITS = 12
) (
   input  mem_pkg::cpu_bus_t             bus,
   input  logic [mem_pkg::DATA_BITS-1:0] int_rdata,
   input  logic [mem_pkg::DATA_BITS-1:0] ext_rdata,
   input  logic                          int_ready,
   input  logic                          ext_ready,
   output logic                          int_cs_b,
   output logic                          ext_cs_b,
   output logic [mem_pkg::DATA_BITS-1:0] rdata,
   output logic                          cpu_clken
);

   import mem_pkg::*;

   logic mem_access;
   logic low_space;

   // IO space wins over program and data space
   assign mem_access = (bus.vpa || bus.vda) && !bus.vio;

   // Block RAM covers the bottom 2**RAM_ADDR_BITS words
   assign low_space = ~|bus.address[ADDR_BITS-1:RAM_ADDR_BITS];

   assign int_cs_b = !(mem_access && low_space);
   assign ext_cs_b = !(mem_access && !low_space);

   // Read word and stall come from whichever memory is selected
   always_comb
   begin
      if (!int_cs_b)
      begin
         rdata     = int_rdata;
         cpu_clken = int_ready;
      end
      else if (!ext_cs_b)
      begin
         rdata     = ext_rdata;
         cpu_clken = ext_ready;
      end
      else
      begin
         // IO and idle cycles complete at once and read zero
         rdata     = '0;
         cpu_clken = 1'b1;
      end
   end

endmodule

// File: memory_subsystem.sv
`timescale 1ns/10ps

module memory_subsystem #(
   parameter int RAM_ADDR_BITS = 12
) (
   input  logic                          clk,
   input  logic                          pwr_up_reset_b,
   input  mem_pkg::cpu_bus_t             bus,
   input  logic [mem_pkg::HALF_BITS-1:0] sram_data_in,
   output logic [mem_pkg::DATA_BITS-1:0] rdata,
   output logic                          cpu_clken,
   output mem_pkg::sram_pins_t           sram
);

   import mem_pkg::*;

   logic                 int_cs_b;
   logic                 ext_cs_b;
   logic [DATA_BITS-1:0] int_rdata;
   logic [DATA_BITS-1:0] ext_rdata;
   logic                 int_ready;
   logic                 ext_ready;

   bus_decoder #(
      .RAM_ADDR_BITS (RAM_ADDR_BITS)
   ) i_bus_decoder (
      .bus       (bus),
      .int_rdata (int_rdata),
      .ext_rdata (ext_rdata),
      .int_ready (int_ready),
      .ext_ready (ext_ready),
      .int_cs_b  (int_cs_b),
      .ext_cs_b  (ext_cs_b),
      .rdata     (rdata),
      .cpu_clken (cpu_clken)
   );

   // Internal RAM sees only the low word-address bits
   block_ram #(
      .RAM_ADDR_BITS (RAM_ADDR_BITS)
   ) i_block_ram (
      .clk            (clk),
      .pwr_up_reset_b (pwr_up_reset_b),
      .cs_b           (int_cs_b),
      .rnw            (bus.rnw),
      .address        (bus.address[RAM_ADDR_BITS-1:0]),
      .wdata          (bus.wdata),
      .rdata          (int_rdata),
      .ready          (int_ready)
   );

   sram_controller i_sram_controller (
      .clk            (clk),
      .pwr_up_reset_b (pwr_up_reset_b),
      .cs_b           (ext_cs_b),
      .rnw            (bus.rnw),
      .address        (bus.address),
      .wdata          (bus.wdata),
      .sram_data_in   (sram_data_in),
      .rdata          (ext_rdata),
      .ready          (ext_ready),
      .sram           (sram)
   );

endmodule

// File: memory_subsystem_properties.sv
`timescale 1ns/10ps

module memory_subsystem_properties (
   input logic                clk,
   input logic                pwr_up_reset_b,
   input logic                cpu_clken,
   input mem_pkg::sram_pins_t sram
);

   int unsigned stall_cycles;
   int unsigned fail_count = 0;
   logic        failed;

   // Consecutive cycles with the CPU held off
   always_ff @(posedge clk)
   begin
      if (!pwr_up_reset_b || cpu_clken)
         stall_cycles <= 0;
      else
         stall_cycles <= stall_cycles + 1;
   end

   assign failed = (fail_count != 0);

   a_oe_we_apart: assert property (@(posedge clk) disable iff (!pwr_up_reset_b)
      sram.oe_b || sram.we_b)
   else
   begin
      $error("SRAM oe_b and we_b are low together");
      fail_count++;
   end

   a_drive_on_write: assert property (@(posedge clk) disable iff (!pwr_up_reset_b)
      sram.data_oe |-> !sram.we_b)
   else
   begin
      $error("SRAM data bus driven outside a write strobe");
      fail_count++;
   end

   // Longest access is the SRAM word, three stall cycles
   a_stall_bound: assert property (@(posedge clk) disable iff (!pwr_up_reset_b)
      stall_cycles <= 3)
   else
   begin
      $error("cpu_clken stayed low for more than 3 cycles");
      fail_count++;
   end

endmodule

bind memory_subsystem memory_subsystem_properties i_properties (
   .clk            (clk),
   .pwr_up_reset_b (pwr_up_reset_b),
   .cpu_clken      (cpu_clken),
   .sram           (sram)
);

// File: tb_memory_subsystem.sv
`timescale 1ns/10ps

module tb_memory_subsystem;

   import mem_pkg::*;

   localparam int RAM_ADDR_BITS = 12;
   localparam int NUM_DIRECTED  = 13;
   localparam int NUM_RANDOM    = 400;
   localparam int WATCHDOG_NS   = ((NUM_DIRECTED + NUM_RANDOM) * 6 + 50) * 4;

   // Strobes as {vpa, vda, vio}
   localparam logic [2:0] STB_DATA    = 3'b010;
   localparam logic [2:0] STB_PROG    = 3'b100;
   localparam logic [2:0] STB_IO      = 3'b011;
   localparam logic [2:0] STB_IO_PROG = 3'b101;
   localparam logic [2:0] STB_NONE    = 3'b000;

   logic                 clk = 1'b0;
   logic                 pwr_up_reset_b;
   cpu_bus_t             bus;
   logic [HALF_BITS-1:0] sram_data_in;
   logic [DATA_BITS-1:0] rdata;
   logic                 cpu_clken;
   sram_pins_t           sram;
   logic [31:0]          rng_state = 32'h20205207;

   // SRAM model; cells never written read back the fill pattern
   logic [HALF_BITS-1:0] sram_mem   [2**SRAM_ADDR_BITS];
   bit                   sram_valid [2**SRAM_ADDR_BITS];
   logic [DATA_BITS-1:0] ref_mem    [logic [ADDR_BITS-1:0]];

   memory_subsystem #(
      .RAM_ADDR_BITS (RAM_ADDR_BITS)
   ) i_dut (
      .clk            (clk),
      .pwr_up_reset_b (pwr_up_reset_b),
      .bus            (bus),
      .sram_data_in   (sram_data_in),
      .rdata          (rdata),
      .cpu_clken      (cpu_clken),
      .sram           (sram)
   );

   always #2 clk = ~clk;

   function automatic logic [31:0] next_random();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   function automatic logic [DATA_BITS-1:0] fill_word(input logic [ADDR_BITS-1:0] address);
      return (32'(address) * 32'h9E3779B1) ^ 32'h5A5A0F0F;
   endfunction

   function automatic logic [HALF_BITS-1:0] fill_half(input logic [SRAM_ADDR_BITS-1:0] addr);
      logic [DATA_BITS-1:0] word;
      word = fill_word(ADDR_BITS'(addr[SRAM_ADDR_BITS-1:1]));
      return addr[0] ? word[DATA_BITS-1:HALF_BITS] : word[HALF_BITS-1:0];
   endfunction

   // Asynchronous SRAM read path, driven only with chip select and output enable low
   assign sram_data_in = (sram.cs_b || sram.oe_b) ? '0 :
                         (sram_valid[sram.addr] ? sram_mem[sram.addr] : fill_half(sram.addr));

   always @(negedge clk)
   begin
      if (!sram.cs_b && !sram.we_b)
      begin
         if (sram.data_oe !== 1'b1)
         begin
            $display("SRAM write strobe seen while the controller does not drive the data bus");
            stop_with_failure();
         end
         sram_mem[sram.addr]   <= sram.data_out;
         sram_valid[sram.addr] <= 1'b1;
      end
   end

   task automatic stop_with_failure();
      $display("Finished with errors");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_word(input string name, input logic [DATA_BITS-1:0] actual,
                             input logic [DATA_BITS-1:0] expected);
      if (actual !== expected)
      begin
         $display("** Error: %s expected 0x%h got 0x%h at %0t", name, expected, actual, $time);
         stop_with_failure();
      end
   endtask

   task automatic check_cycles(input string name, input int actual, input int expected);
      if (actual != expected)
      begin
         $display("** Error: %s expected 0x%0h got 0x%0h at %0t", name, expected, actual, $time);
         stop_with_failure();
      end
   endtask

   // Only the strobes are compared, address and data may hold anything when idle
   task automatic check_pins(input string name, input sram_pins_t actual,
                             input sram_pins_t expected);
      if (actual.cs_b !== expected.cs_b || actual.oe_b !== expected.oe_b ||
          actual.we_b !== expected.we_b || actual.data_oe !== expected.data_oe)
      begin
         $display("** Error: %s expected 0x%h got 0x%h at %0t", name, expected, actual, $time);
         stop_with_failure();
      end
   endtask

   // Called 1 ns after a rising edge, returns 1 ns after the completing edge
   task automatic do_access(input cpu_bus_t req);
      logic [DATA_BITS-1:0] data;
      int                   stalls;
      logic                 mem_access;
      logic                 internal;
      mem_access = (req.vpa || req.vda) && !req.vio;
      internal   = mem_access && ((req.address >> RAM_ADDR_BITS) == '0);
      stalls     = 0;
      bus        = req;
      @(negedge clk);
      while (cpu_clken !== 1'b1)
      begin
         stalls++;
         @(negedge clk);
      end
      data = rdata;
      @(posedge clk);
      #1;
      check_cycles("stall cycles", stalls, !mem_access ? 0 : (internal ? 1 : 3));
      if (!mem_access)
         check_word("rdata", data, '0);
      else if (!req.rnw)
         ref_mem[req.address] = req.wdata;
      else if (ref_mem.exists(req.address))
         check_word("rdata", data, ref_mem[req.address]);
      else if (!internal)
         check_word("rdata", data, fill_word(req.address));
   endtask

   task automatic check_sram_halves(input logic [ADDR_BITS-1:0] address,
                                    input logic [DATA_BITS-1:0] word);
      logic [SRAM_ADDR_BITS-1:0] even_addr;
      logic [SRAM_ADDR_BITS-1:0] odd_addr;
      even_addr = {address[SRAM_ADDR_BITS-2:0], 1'b0};
      odd_addr  = {address[SRAM_ADDR_BITS-2:0], 1'b1};
      check_word("sram_mem low half", DATA_BITS'(sram_mem[even_addr]),
                 DATA_BITS'(word[HALF_BITS-1:0]));
      check_word("sram_mem high half", DATA_BITS'(sram_mem[odd_addr]),
                 DATA_BITS'(word[DATA_BITS-1:HALF_BITS]));
   endtask

   // Windows of 16 words so reads keep hitting earlier writes
   task automatic random_request();
      logic [31:0]          r;
      logic [DATA_BITS-1:0] data;
      logic [2:0]           strobes;
      logic [ADDR_BITS-1:0] address;
      r       = next_random();
      data    = next_random();
      strobes = (r[29] && r[28]) ? STB_PROG : STB_DATA;
      case (r[31:30])
         2'd0: address = (r[27] ? 20'h00FF0 : 20'h00000) + ADDR_BITS'(r[26:23]);
         2'd1: address = (r[27] ? 20'h1FFF0 : 20'h01000) + ADDR_BITS'(r[26:23]);
         2'd2:
         begin
            strobes = r[28] ? STB_IO_PROG : STB_IO;
            address = data[31:12];
         end
         default:
         begin
            strobes = STB_NONE;
            address = data[31:12];
         end
      endcase
      do_access({strobes, r[29], address, data});
   endtask

   always @(negedge clk)
   begin
      if (i_dut.i_properties.failed)
      begin
         $display("A concurrent assertion on the DUT failed");
         stop_with_failure();
      end
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns with a request still pending", WATCHDOG_NS);
      stop_with_failure();
   end

   initial
   begin
      sram_pins_t idle_pins;
      pwr_up_reset_b = 1'b0;
      bus            = '0;
      repeat (5) @(posedge clk);
      #1;
      pwr_up_reset_b = 1'b1;
      // One idle cycle lets the block RAM wait-state register settle
      @(posedge clk);
      #1;
      idle_pins      = '0;
      idle_pins.cs_b = 1'b1;
      idle_pins.oe_b = 1'b1;
      idle_pins.we_b = 1'b1;
      check_cycles("cpu_clken", int'(cpu_clken), 1);
      check_pins("sram", sram, idle_pins);

      do_access({STB_DATA, 1'b0, 20'h00005, 32'hCAFE0005});
      do_access({STB_DATA, 1'b1, 20'h00005, 32'h0});
      do_access({STB_DATA, 1'b0, 20'h00FFF, 32'h0BAD0FFF});
      do_access({STB_PROG, 1'b1, 20'h00FFF, 32'h0});
      do_access({STB_DATA, 1'b0, 20'h1F00A, 32'h1234ABCD});
      check_sram_halves(20'h1F00A, 32'h1234ABCD);
      do_access({STB_DATA, 1'b1, 20'h1F00A, 32'h0});

      // First words above the block RAM belong to the SRAM
      do_access({STB_DATA, 1'b0, 20'h01000, 32'h87654321});
      do_access({STB_DATA, 1'b0, 20'h01001, 32'hF00DBEEF});
      check_sram_halves(20'h01000, 32'h87654321);
      check_sram_halves(20'h01001, 32'hF00DBEEF);
      do_access({STB_DATA, 1'b1, 20'h01000, 32'h0});
      do_access({STB_PROG, 1'b1, 20'h01001, 32'h0});

      do_access({STB_IO, 1'b1, 20'h00010, 32'h0});
      do_access({STB_IO_PROG, 1'b0, 20'h00020, 32'hFFFFFFFF});
      do_access({STB_NONE, 1'b1, 20'h00005, 32'h0});

      for (int i = 0; i < NUM_RANDOM; i++)
         random_request();

      @(negedge clk);
      if (i_dut.i_properties.failed)
      begin
         $display("A concurrent assertion on the DUT failed");
         stop_with_failure();
      end
      else
      begin
         $display("Finished with no errors");
         $finish;
      end
   end

endmodule

// File: all.f
mem_pkg.sv
block_ram.sv
sram_controller.sv
bus_decoder.sv
memory_subsystem.sv
memory_subsystem_properties.sv
tb_memory_subsystem.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f all.f --top-module tb_memory_subsystem
	./obj_dir/Vtb_memory_subsystem +verilator+error+limit+100 | tee /dev/stderr \
		| grep -x "Finished with no errors" > /dev/null

clean:
	rm -rf obj_dir
